//--- common/conv_pkg.sv
package conv_pkg;

  // Word widths of the datapath
  localparam int PIXEL_W   = 8;
  localparam int WEIGHT_W  = 8;
  localparam int PRODUCT_W = PIXEL_W + WEIGHT_W;
  localparam int ACC_W     = 32;

  // Half kernel width, kw = 2*kw2 + 1
  localparam int KW2_W = 2;

  // Signed input pixel
  typedef logic signed [PIXEL_W-1:0] pixel_t;

  // Signed weight, one per member
  typedef logic signed [WEIGHT_W-1:0] weight_t;

  // Full precision multiplier result
  typedef logic signed [PRODUCT_W-1:0] product_t;

  // Accumulator word, wide enough for long input-channel blocks
  typedef logic signed [ACC_W-1:0] acc_t;

  typedef logic [KW2_W-1:0] kw2_t;

  // Step buffer either passes beats or blocks input while the last beat drains
  typedef enum logic {
    S_PASS  = 1'b0,
    S_BLOCK = 1'b1
  } step_state_t;

endpackage

//--- hw/step_buffer.sv
`timescale 1ns/10ps

module step_buffer #(
  parameter int MEMBERS = 6,
  parameter int UNITS   = 2,
  parameter int KW_MAX  = 3
) (
  input  logic                                     clk,
  input  logic                                     clken_mul,
  input  logic                                     reset,
  input  logic                                     s_valid,
  output logic                                     s_ready,
  input  logic                                     s_last,
  input  logic                                     s_cin_last,
  input  conv_pkg::kw2_t                           s_kw2,
  input  conv_pkg::pixel_t  [UNITS-1:0]            s_pixels,
  input  conv_pkg::weight_t [MEMBERS-1:0]          s_weights,
  output logic              [MEMBERS-1:0]          step_valid,
  output logic              [MEMBERS-1:0]          step_last,
  output logic              [MEMBERS-1:0]          step_cin_last,
  output conv_pkg::kw2_t    [MEMBERS-1:0]          step_kw2,
  output logic              [MEMBERS-1:0]          step_sub_base,
  output conv_pkg::pixel_t  [MEMBERS-1:0][UNITS-1:0] step_pixels,
  output conv_pkg::weight_t [MEMBERS-1:0]          step_weights
);

  conv_pkg::step_state_t state, state_next;

  logic accept;

  // One registered copy of the previous beat, shared by all delayed members
  logic                           dly_valid;
  logic                           dly_last;
  logic                           dly_cin_last;
  conv_pkg::kw2_t                 dly_kw2;
  conv_pkg::pixel_t  [UNITS-1:0]  dly_pixels;
  conv_pkg::weight_t [MEMBERS-1:0] dly_weights;

  conv_pkg::kw2_t kw2_cur;

  assign accept  = s_valid && s_ready;
  assign s_ready = (state == conv_pkg::S_PASS) ? clken_mul : 1'b0;

  always_ff @(posedge clk) begin
    if (reset) begin
      dly_valid <= 1'b0;
      dly_last  <= 1'b0;
    end else if (clken_mul) begin
      dly_valid <= accept;
      dly_last  <= accept && s_last;
    end
  end

  always_ff @(posedge clk) begin
    if (clken_mul && accept) begin
      dly_cin_last <= s_cin_last;
      dly_kw2      <= s_kw2;
      dly_pixels   <= s_pixels;
      dly_weights  <= s_weights;
    end
  end

  // While blocked the live kw2 is meaningless, so keep the drained beat's grouping
  assign kw2_cur = (state == conv_pkg::S_PASS) ? s_kw2 : dly_kw2;

  always_comb begin
    step_sub_base = '0;
    for (int k = 0; k <= KW_MAX / 2; k++) begin
      if (kw2_cur == k) begin
        for (int m = 0; m < MEMBERS; m++)
          step_sub_base[m] = (m % (2 * k + 1) == 0);
      end
    end
  end

  always_comb begin
    for (int m = 0; m < MEMBERS; m++) begin
      step_valid[m]    = step_sub_base[m] ? accept     : dly_valid;
      step_last[m]     = step_sub_base[m] ? s_last     : dly_last;
      step_cin_last[m] = step_sub_base[m] ? s_cin_last : dly_cin_last;
      step_kw2[m]      = step_sub_base[m] ? kw2_cur    : dly_kw2;
      step_pixels[m]   = step_sub_base[m] ? s_pixels   : dly_pixels;
      step_weights[m]  = step_sub_base[m] ? s_weights[m] : dly_weights[m];
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      conv_pkg::S_PASS:  if (accept && s_last) state_next = conv_pkg::S_BLOCK;
      conv_pkg::S_BLOCK: if (!(dly_valid && dly_last)) state_next = conv_pkg::S_PASS; // Drained
      default:           state_next = conv_pkg::S_PASS;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset)
      state <= conv_pkg::S_PASS;
    else if (clken_mul)
      state <= state_next;
  end

endmodule

//--- mac_chain/member_control.sv
`timescale 1ns/10ps

module member_control #(
  parameter int MEMBERS             = 6,
  parameter int LATENCY_MULTIPLIER  = 2,
  parameter int LATENCY_ACCUMULATOR = 1
) (
  input  logic                          clk,
  input  logic                          clken,
  input  logic                          reset,
  input  logic           [MEMBERS-1:0]  step_valid,
  input  logic           [MEMBERS-1:0]  step_last,
  input  logic           [MEMBERS-1:0]  step_cin_last,
  input  conv_pkg::kw2_t [MEMBERS-1:0]  step_kw2,
  input  logic           [MEMBERS-1:0]  step_sub_base,
  output logic                          clken_mul,
  output logic           [MEMBERS-1:0]  mux_sel,
  output logic           [MEMBERS-1:0]  clken_acc,
  output logic           [MEMBERS-1:0]  bypass,
  output logic           [MEMBERS-1:0]  mul_valid,
  output logic           [MEMBERS-1:0]  acc_valid,
  output logic           [MEMBERS-1:0]  acc_last,
  output conv_pkg::kw2_t [MEMBERS-1:0]  acc_kw2
);

  // Valid leaves one stage after the accumulator register, plus the output stages
  localparam int ACC_STAGES = LATENCY_ACCUMULATOR + 1;

  logic           [MEMBERS-1:0] mv_pipe [LATENCY_MULTIPLIER];
  logic           [MEMBERS-1:0] ml_pipe [LATENCY_MULTIPLIER];
  logic           [MEMBERS-1:0] mc_pipe [LATENCY_MULTIPLIER];
  logic           [MEMBERS-1:0] mb_pipe [LATENCY_MULTIPLIER];
  conv_pkg::kw2_t [MEMBERS-1:0] mk_pipe [LATENCY_MULTIPLIER];

  logic           [MEMBERS-1:0] av_pipe [ACC_STAGES];
  logic           [MEMBERS-1:0] al_pipe [ACC_STAGES];
  conv_pkg::kw2_t [MEMBERS-1:0] ak_pipe [ACC_STAGES];

  logic [MEMBERS-1:0] mul_v, mul_last, mul_cin_last, mul_sub_base;
  logic [MEMBERS-1:0] sel_q, sel_en, sel_next, prev_sel, prev_valid;
  logic [MEMBERS-1:0] own_valid, in_valid, bypass_q, last_hold, vd_in, ld_in;
  logic               mux_sel_none;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < LATENCY_MULTIPLIER; i++) begin
        mv_pipe[i] <= '0;
        ml_pipe[i] <= '0;
        mc_pipe[i] <= '0;
        mb_pipe[i] <= '0;
        mk_pipe[i] <= '0;
      end
    end else if (clken_mul) begin
      mv_pipe[0] <= step_valid;
      ml_pipe[0] <= step_last;
      mc_pipe[0] <= step_cin_last;
      mb_pipe[0] <= step_sub_base;
      mk_pipe[0] <= step_kw2;
      for (int i = 1; i < LATENCY_MULTIPLIER; i++) begin
        mv_pipe[i] <= mv_pipe[i-1];
        ml_pipe[i] <= ml_pipe[i-1];
        mc_pipe[i] <= mc_pipe[i-1];
        mb_pipe[i] <= mb_pipe[i-1];
        mk_pipe[i] <= mk_pipe[i-1];
      end
    end
  end

  assign mul_v        = mv_pipe[LATENCY_MULTIPLIER-1];
  assign mul_last     = ml_pipe[LATENCY_MULTIPLIER-1];
  assign mul_cin_last = mc_pipe[LATENCY_MULTIPLIER-1];
  assign mul_sub_base = mb_pipe[LATENCY_MULTIPLIER-1];

  // Any non-base member pulling its neighbor freezes the multipliers
  assign mux_sel_none = ~|(sel_q & ~mul_sub_base);
  assign clken_mul    = clken && mux_sel_none;
  assign mux_sel      = sel_q;
  assign mul_valid    = mul_v & {MEMBERS{clken_mul}};
  assign own_valid    = mul_valid & ~sel_q;

  assign prev_sel   = {sel_q[MEMBERS-2:0], 1'b0};
  assign prev_valid = {acc_valid[MEMBERS-2:0], 1'b0};

  always_comb begin
    for (int m = 0; m < MEMBERS; m++) begin
      // Selecting members wait until the lower neighbor has its finished sum
      if (mul_sub_base[m])
        clken_acc[m] = clken_mul;
      else if (sel_q[m])
        clken_acc[m] = clken && !prev_sel[m] && prev_valid[m];
      else
        clken_acc[m] = clken;
      in_valid[m] = sel_q[m] || own_valid[m];
      sel_en[m]   = clken_acc[m] && in_valid[m];
      sel_next[m] = (m != 0) && !sel_q[m] && mul_cin_last[m] && !mul_sub_base[m];
      bypass[m]   = bypass_q[m] && own_valid[m]; // First beat of a block loads
      vd_in[m]    = mul_sub_base[m] ? (own_valid[m] && mul_cin_last[m]) : sel_q[m];
      ld_in[m]    = vd_in[m] && (mul_sub_base[m] ? mul_last[m] : last_hold[m]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sel_q     <= '0;
      bypass_q  <= '1;
      last_hold <= '0;
    end else begin
      for (int m = 0; m < MEMBERS; m++) begin
        if (sel_en[m])
          sel_q[m] <= sel_next[m];
        if (clken_acc[m] && own_valid[m]) begin
          bypass_q[m]  <= mul_cin_last[m];
          last_hold[m] <= mul_last[m]; // Kept for the chained result
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < ACC_STAGES; i++) begin
        av_pipe[i] <= '0;
        al_pipe[i] <= '0;
        ak_pipe[i] <= '0;
      end
    end else begin
      for (int m = 0; m < MEMBERS; m++) begin
        if (clken_acc[m]) begin
          av_pipe[0][m] <= vd_in[m];
          al_pipe[0][m] <= ld_in[m];
          ak_pipe[0][m] <= mk_pipe[LATENCY_MULTIPLIER-1][m];
          for (int i = 1; i < ACC_STAGES; i++) begin
            av_pipe[i][m] <= av_pipe[i-1][m];
            al_pipe[i][m] <= al_pipe[i-1][m];
            ak_pipe[i][m] <= ak_pipe[i-1][m];
          end
        end
      end
    end
  end

  assign acc_valid = av_pipe[ACC_STAGES-1];
  assign acc_last  = al_pipe[ACC_STAGES-1];
  assign acc_kw2   = ak_pipe[ACC_STAGES-1];

endmodule

//--- mac_chain/mac_lane.sv
`timescale 1ns/10ps

module mac_lane #(
  parameter int LATENCY_MULTIPLIER  = 2,
  parameter int LATENCY_ACCUMULATOR = 1
) (
  input  logic              clk,
  input  logic              clken_mul,
  input  logic              clken_acc,
  input  logic              mux_sel,
  input  logic              mul_valid,
  input  logic              bypass,
  input  conv_pkg::pixel_t  pixel,
  input  conv_pkg::weight_t weight,
  input  conv_pkg::acc_t    neighbor_acc,
  output conv_pkg::acc_t    acc
);

  conv_pkg::product_t prod_pipe [LATENCY_MULTIPLIER];
  conv_pkg::acc_t     out_pipe  [LATENCY_ACCUMULATOR];
  conv_pkg::acc_t     acc_in;
  conv_pkg::acc_t     acc_reg;

  always_ff @(posedge clk) begin
    if (clken_mul) begin
      prod_pipe[0] <= pixel * weight;
      for (int i = 1; i < LATENCY_MULTIPLIER; i++)
        prod_pipe[i] <= prod_pipe[i-1];
    end
  end

  // Invalid products add zero so the running sum holds
  always_comb begin
    if (mux_sel)
      acc_in = neighbor_acc;
    else if (mul_valid)
      acc_in = conv_pkg::acc_t'(prod_pipe[LATENCY_MULTIPLIER-1]); // Sign extended
    else
      acc_in = '0;
  end

  always_ff @(posedge clk) begin
    if (clken_acc) begin
      acc_reg     <= bypass ? acc_in : acc_reg + acc_in;
      out_pipe[0] <= acc_reg;
      for (int i = 1; i < LATENCY_ACCUMULATOR; i++)
        out_pipe[i] <= out_pipe[i-1];
    end
  end

  assign acc = out_pipe[LATENCY_ACCUMULATOR-1];

endmodule

//--- hw/output_mask.sv
`timescale 1ns/10ps

module output_mask #(
  parameter int MEMBERS = 6
) (
  input  logic           [MEMBERS-1:0] clken_acc,
  input  logic           [MEMBERS-1:0] acc_valid,
  input  logic           [MEMBERS-1:0] acc_last,
  input  conv_pkg::kw2_t [MEMBERS-1:0] acc_kw2,
  input  logic           [MEMBERS-1:0] mux_sel,
  output logic           [MEMBERS-1:0] m_member_valid,
  output logic                         m_valid,
  output logic                         m_last
);

  logic [MEMBERS-1:0] group_top, last_member, upper_sel;

  // A partial sum being pulled by the member above is not a result
  assign upper_sel = {1'b0, mux_sel[MEMBERS-1:1]};

  always_comb begin
    group_top   = '0;
    last_member = '0;
    for (int m = 0; m < MEMBERS; m++) begin
      for (int k = 0; k < (1 << conv_pkg::KW2_W); k++) begin
        if (acc_kw2[m] == k) begin
          group_top[m]   = (m % (2 * k + 1) == 2 * k);
          last_member[m] = (m == (MEMBERS / (2 * k + 1)) * (2 * k + 1) - 1);
        end
      end
    end
  end

  assign m_member_valid = clken_acc & acc_valid & group_top & ~upper_sel;
  assign m_valid        = |m_member_valid;
  assign m_last         = |(m_member_valid & acc_last & last_member); // Highest full group only

endmodule

//--- hw/conv_engine.sv
`timescale 1ns/10ps

module conv_engine #(
  parameter int MEMBERS             = 6,
  parameter int UNITS               = 2,
  parameter int KW_MAX              = 3,
  parameter int LATENCY_MULTIPLIER  = 2,
  parameter int LATENCY_ACCUMULATOR = 1
) (
  input  logic                                   clk,
  input  logic                                   clken,
  input  logic                                   reset,
  input  logic                                   s_valid,
  output logic                                   s_ready,
  input  logic                                   s_last,
  input  logic                                   s_cin_last,
  input  conv_pkg::kw2_t                         s_kw2,
  input  conv_pkg::pixel_t  [UNITS-1:0]          s_pixels,
  input  conv_pkg::weight_t [MEMBERS-1:0]        s_weights,
  output logic                                   m_valid,
  output logic                                   m_last,
  output logic              [MEMBERS-1:0]        m_member_valid,
  output conv_pkg::acc_t    [MEMBERS-1:0][UNITS-1:0] m_data
);

  logic                                      clken_mul;
  logic              [MEMBERS-1:0]           step_valid, step_last, step_cin_last, step_sub_base;
  conv_pkg::kw2_t    [MEMBERS-1:0]           step_kw2, acc_kw2;
  conv_pkg::pixel_t  [MEMBERS-1:0][UNITS-1:0] step_pixels;
  conv_pkg::weight_t [MEMBERS-1:0]           step_weights;
  logic              [MEMBERS-1:0]           mux_sel, clken_acc, bypass, mul_valid;
  logic              [MEMBERS-1:0]           acc_valid, acc_last;

  step_buffer #(
    .MEMBERS (MEMBERS),
    .UNITS   (UNITS),
    .KW_MAX  (KW_MAX)
  ) step_buffer0 (
    .clk           (clk),
    .clken_mul     (clken_mul),
    .reset         (reset),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .s_last        (s_last),
    .s_cin_last    (s_cin_last),
    .s_kw2         (s_kw2),
    .s_pixels      (s_pixels),
    .s_weights     (s_weights),
    .step_valid    (step_valid),
    .step_last     (step_last),
    .step_cin_last (step_cin_last),
    .step_kw2      (step_kw2),
    .step_sub_base (step_sub_base),
    .step_pixels   (step_pixels),
    .step_weights  (step_weights)
  );

  member_control #(
    .MEMBERS             (MEMBERS),
    .LATENCY_MULTIPLIER  (LATENCY_MULTIPLIER),
    .LATENCY_ACCUMULATOR (LATENCY_ACCUMULATOR)
  ) member_control0 (
    .clk           (clk),
    .clken         (clken),
    .reset         (reset),
    .step_valid    (step_valid),
    .step_last     (step_last),
    .step_cin_last (step_cin_last),
    .step_kw2      (step_kw2),
    .step_sub_base (step_sub_base),
    .clken_mul     (clken_mul),
    .mux_sel       (mux_sel),
    .clken_acc     (clken_acc),
    .bypass        (bypass),
    .mul_valid     (mul_valid),
    .acc_valid     (acc_valid),
    .acc_last      (acc_last),
    .acc_kw2       (acc_kw2)
  );

  // Lanes chained by member, member 0 has no neighbor
  for (genvar m = 0; m < MEMBERS; m++) begin : g_member
    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      mac_lane #(
        .LATENCY_MULTIPLIER  (LATENCY_MULTIPLIER),
        .LATENCY_ACCUMULATOR (LATENCY_ACCUMULATOR)
      ) lane (
        .clk          (clk),
        .clken_mul    (clken_mul),
        .clken_acc    (clken_acc[m]),
        .mux_sel      ((m == 0) ? 1'b0 : mux_sel[m]),
        .mul_valid    (mul_valid[m]),
        .bypass       (bypass[m]),
        .pixel        (step_pixels[m][u]),
        .weight       (step_weights[m]),
        .neighbor_acc ((m == 0) ? conv_pkg::acc_t'(0) : m_data[(m == 0) ? 0 : m-1][u]),
        .acc          (m_data[m][u])
      );
    end
  end

  output_mask #(
    .MEMBERS (MEMBERS)
  ) output_mask0 (
    .clken_acc      (clken_acc),
    .acc_valid      (acc_valid),
    .acc_last       (acc_last),
    .acc_kw2        (acc_kw2),
    .mux_sel        (mux_sel),
    .m_member_valid (m_member_valid),
    .m_valid        (m_valid),
    .m_last         (m_last)
  );

endmodule

//--- testbench/conv_engine_tests.svh
`ifndef CONV_ENGINE_TESTS_SVH
`define CONV_ENGINE_TESTS_SVH

// Signed value in the range -8 to 7
function automatic conv_pkg::pixel_t draw_small_value();
  int v;
  v = $urandom_range(15);
  return conv_pkg::pixel_t'(v - 8);
endfunction

function automatic int pending_results();
  int n;
  n = 0;
  for (int m = 0; m < MEMBERS; m++)
    n += exp_wr[m] - exp_rd[m];
  return n;
endfunction

task automatic print_counts();
  $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
endtask

task automatic clear_block();
  for (int m = 0; m < MEMBERS; m++)
    for (int u = 0; u < UNITS; u++)
      blk_sum[m][u] = '0;
endtask

// Group top t gets the block sums of members t-kw+1 through t
task automatic push_expected(input int kw, input logic final_block);
  conv_pkg::acc_t total;
  int             last_top;
  last_top = (MEMBERS / kw) * kw - 1;
  for (int t = kw - 1; t < MEMBERS; t += kw) begin
    for (int u = 0; u < UNITS; u++) begin
      total = '0;
      for (int j = t - kw + 1; j <= t; j++)
        total += blk_sum[j][u];
      exp_sum[t][u][exp_wr[t] % DEPTH] = total;
    end
    exp_last[t][exp_wr[t] % DEPTH] = final_block && (t == last_top);
    exp_wr[t]++;
  end
  clear_block();
endtask

// Starts and ends on a falling edge, holds the beat until it is taken
task automatic send_beat(input conv_pkg::kw2_t kw2, input logic cin_last,
                         input logic last, input int stall_max);
  logic taken;
  int   idle;
  idle = (stall_max > 0) ? $urandom_range(stall_max) : 0;
  repeat (idle) @(negedge clk);
  s_valid    = 1'b1;
  s_kw2      = kw2;
  s_cin_last = cin_last;
  s_last     = last;
  for (int u = 0; u < UNITS; u++)
    s_pixels[u] = draw_small_value();
  for (int m = 0; m < MEMBERS; m++)
    s_weights[m] = draw_small_value();
  taken = 1'b0;
  while (!taken) begin
    #1;
    taken = s_ready && clken;
    @(posedge clk);
    if (!taken)
      @(negedge clk);
  end
  for (int m = 0; m < MEMBERS; m++)
    for (int u = 0; u < UNITS; u++)
      blk_sum[m][u] += conv_pkg::acc_t'(s_pixels[u]) * conv_pkg::acc_t'(s_weights[m]);
  quiet = 1'b0;
  if (cin_last)
    push_expected(2 * kw2 + 1, last);
  @(negedge clk);
  s_valid    = 1'b0;
  s_cin_last = 1'b0;
  s_last     = 1'b0;
endtask

task automatic send_block(input conv_pkg::kw2_t kw2, input int beats,
                          input logic final_block, input int stall_max);
  for (int b = 0; b < beats; b++)
    send_beat(kw2, b == beats - 1, final_block && (b == beats - 1), stall_max);
endtask

task automatic wait_results();
  int waited;
  waited = 0;
  while (pending_results() != 0 && waited < DRAIN_LIMIT) begin
    @(negedge clk);
    waited++;
  end
  for (int m = 0; m < MEMBERS; m++) begin
    assert (exp_rd[m] == exp_wr[m]) else begin
      other_errors += exp_wr[m] - exp_rd[m];
      $display("Member %0d never delivered %0d expected result(s)", m, exp_wr[m] - exp_rd[m]);
      exp_rd[m] = exp_wr[m];
    end
  end
endtask

task automatic test_kw1_block();
  send_block(2'd0, 4, 1'b1, 0);  // Every member is its own group
  wait_results();
endtask

task automatic test_kw3_block();
  send_block(2'd1, 5, 1'b1, 0);
  wait_results();
endtask

task automatic test_back_to_back();
  send_block(2'd1, 3, 1'b0, 3);
  send_block(2'd1, 6, 1'b0, 3);
  send_block(2'd1, 2, 1'b1, 3);
  wait_results();
endtask

task automatic test_clken_stall();
  clken_stall = 1'b1;
  send_block(2'd0, 6, 1'b1, 0);
  wait_results();
  clken_stall = 1'b0;
  @(negedge clk);
endtask

task automatic test_last_and_reset();
  int seen;
  seen = last_seen;
  send_block(2'd0, 2, 1'b0, 0);
  send_block(2'd0, 3, 1'b1, 0);
  wait_results();
  assert (last_seen - seen == 1) else begin
    other_errors++;
    $display("m_last was high %0d times in the kw=1 stream instead of once", last_seen - seen);
  end
  seen = last_seen;
  send_block(2'd1, 3, 1'b0, 0);
  send_block(2'd1, 2, 1'b1, 0);
  wait_results();
  assert (last_seen - seen == 1) else begin
    other_errors++;
    $display("m_last was high %0d times in the kw=3 stream instead of once", last_seen - seen);
  end
  // Reset in the middle of an unfinished block
  send_beat(2'd0, 1'b0, 1'b0, 0);
  send_beat(2'd0, 1'b0, 1'b0, 0);
  reset = 1'b1;
  quiet = 1'b1;
  repeat (4) @(negedge clk);
  reset = 1'b0;
  clear_block();
  repeat (20) @(negedge clk);
  send_block(2'd0, 3, 1'b1, 0);
  wait_results();
endtask

`endif

//--- testbench/conv_engine_tb.sv
`timescale 1ns/10ps

module conv_engine_tb;

  localparam int MEMBERS             = 6;
  localparam int UNITS               = 2;
  localparam int KW_MAX              = 3;
  localparam int LATENCY_MULTIPLIER  = 2;
  localparam int LATENCY_ACCUMULATOR = 1;

  localparam int SEED           = 51588;
  localparam int DEPTH          = 16;  // Scoreboard slots per member
  localparam int DRAIN_LIMIT    = 80;  // Cycles allowed for pending results after the last beat
  localparam int TOTAL_BEATS    = 41;  // Sum of the beats driven by all tests
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS + 200;

  logic                                      clk;
  logic                                      clken;
  logic                                      reset;
  logic                                      s_valid;
  logic                                      s_ready;
  logic                                      s_last;
  logic                                      s_cin_last;
  conv_pkg::kw2_t                            s_kw2;
  conv_pkg::pixel_t  [UNITS-1:0]             s_pixels;
  conv_pkg::weight_t [MEMBERS-1:0]           s_weights;
  logic                                      m_valid;
  logic                                      m_last;
  logic              [MEMBERS-1:0]           m_member_valid;
  conv_pkg::acc_t    [MEMBERS-1:0][UNITS-1:0] m_data;

  // Reference model state and expected results per member
  conv_pkg::acc_t blk_sum [MEMBERS][UNITS];
  conv_pkg::acc_t exp_sum [MEMBERS][UNITS][DEPTH];
  logic           exp_last [MEMBERS][DEPTH];
  int             exp_wr [MEMBERS];
  int             exp_rd [MEMBERS];

  int   mismatch_count = 0;
  int   other_errors   = 0;
  int   last_seen      = 0;  // Cycles with m_last high
  int   cycle_count    = 0;
  logic quiet          = 1'b0;  // No output may appear while set
  logic clken_stall    = 1'b0;

  conv_engine #(
    .MEMBERS             (MEMBERS),
    .UNITS               (UNITS),
    .KW_MAX              (KW_MAX),
    .LATENCY_MULTIPLIER  (LATENCY_MULTIPLIER),
    .LATENCY_ACCUMULATOR (LATENCY_ACCUMULATOR)
  ) dut0 (
    .clk            (clk),
    .clken          (clken),
    .reset          (reset),
    .s_valid        (s_valid),
    .s_ready        (s_ready),
    .s_last         (s_last),
    .s_cin_last     (s_cin_last),
    .s_kw2          (s_kw2),
    .s_pixels       (s_pixels),
    .s_weights      (s_weights),
    .m_valid        (m_valid),
    .m_last         (m_last),
    .m_member_valid (m_member_valid),
    .m_data         (m_data)
  );

  `include "conv_engine_tests.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Global enable goes randomly low while a stall test runs
  initial begin
    clken = 1'b1;
    forever begin
      @(negedge clk);
      clken = clken_stall ? ($urandom_range(2) != 0) : 1'b1;
    end
  end

  // Output collector sampled 1 ns after the falling edge
  initial begin
    logic exp_m_last;
    logic exp_m_valid;
    int   idx;
    forever begin
      @(negedge clk);
      #1;
      if (!reset) begin
        exp_m_last  = 1'b0;
        exp_m_valid = 1'b0;
        assert (!(quiet && m_valid)) else begin
          other_errors++;
          $display("Output valid raised at %0t although no beat was sent since reset", $time);
        end
        assert (clken || !m_valid) else begin
          other_errors++;
          $display("Output valid raised at %0t while clken was low", $time);
        end
        for (int m = 0; m < MEMBERS; m++) begin
          if (m_member_valid[m]) begin
            assert (exp_rd[m] != exp_wr[m]) else begin
              other_errors++;
              $display("Member %0d delivered a result at %0t that was not expected", m, $time);
            end
            if (exp_rd[m] != exp_wr[m]) begin
              idx = exp_rd[m] % DEPTH;
              for (int u = 0; u < UNITS; u++) begin
                assert (m_data[m][u] === exp_sum[m][u][idx]) else begin
                  mismatch_count++;
                  $display("Mismatch at %0t: member %0d unit %0d sum %0d, expected %0d",
                           $time, m, u, m_data[m][u], exp_sum[m][u][idx]);
                end
              end
              exp_m_last  = exp_m_last | exp_last[m][idx];
              exp_m_valid = 1'b1;
              exp_rd[m]++;
            end
          end
        end
        assert (m_valid === exp_m_valid) else begin
          mismatch_count++;
          $display("Mismatch at %0t: m_valid is %b, expected %b", $time, m_valid, exp_m_valid);
        end
        assert (m_last === exp_m_last) else begin
          mismatch_count++;
          $display("Mismatch at %0t: m_last is %b, expected %b", $time, m_last, exp_m_last);
        end
        if (m_last)
          last_seen++;
      end
    end
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_counts();
    $display("** FAIL **");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    reset      = 1'b1;
    s_valid    = 1'b0;
    s_last     = 1'b0;
    s_cin_last = 1'b0;
    s_kw2      = '0;
    s_pixels   = '0;
    s_weights  = '0;
    for (int m = 0; m < MEMBERS; m++) begin
      exp_wr[m] = 0;
      exp_rd[m] = 0;
    end
    clear_block();
    repeat (4) @(negedge clk);
    reset = 1'b0;

    test_kw1_block();
    test_kw3_block();
    test_back_to_back();
    test_clken_stall();
    test_last_and_reset();

    print_counts();
    if (mismatch_count + other_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- all.f
+incdir+testbench
common/conv_pkg.sv
hw/step_buffer.sv
mac_chain/member_control.sv
mac_chain/mac_lane.sv
hw/output_mask.sv
hw/conv_engine.sv
testbench/conv_engine_tb.sv

//--- Bender.yml
package:
  name: conv_engine

sources:
  - common/conv_pkg.sv
  - hw/step_buffer.sv
  - mac_chain/member_control.sv
  - mac_chain/mac_lane.sv
  - hw/output_mask.sv
  - hw/conv_engine.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/conv_engine_tb.sv
